//--- common/atop_settings.svh
// Width and depth settings for the atomic-operation resolver
// Address, data and id widths plus the response buffer depth

`ifndef ATOP_SETTINGS_SVH
`define ATOP_SETTINGS_SVH

`define ATOP_ADDR_WIDTH 32
`define ATOP_DATA_WIDTH 32
`define ATOP_ID_WIDTH   4

// Entries in each response buffer
`define ATOP_RSP_DEPTH  2

`endif

//--- common/atop_pkg.sv
// Types shared by the atomic-operation resolver
// Bus vectors, the atomic opcode, the sequencer state and the response entry

`include "atop_settings.svh"

package atop_pkg;

  typedef logic [`ATOP_ADDR_WIDTH-1:0] addr_t;
  typedef logic [`ATOP_DATA_WIDTH-1:0] data_t;
  typedef logic [`ATOP_ID_WIDTH-1:0]   id_t;

  // RISC-V AMO function codes with bit 5 marking an atomic
  typedef enum logic [5:0] {
    ATOP_NONE = 6'h00,
    AMO_ADD   = 6'h20,
    AMO_SWAP  = 6'h21,
    ATOP_LR   = 6'h22,
    ATOP_SC   = 6'h23,
    AMO_XOR   = 6'h24,
    AMO_OR    = 6'h28,
    AMO_AND   = 6'h2C,
    AMO_MIN   = 6'h30,
    AMO_MAX   = 6'h34,
    AMO_MINU  = 6'h38,
    AMO_MAXU  = 6'h3C
  } atop_e;

  typedef enum logic [1:0] {
    IDLE,
    WRITE_BACK
  } amo_state_e;

  typedef struct packed {
    id_t   id;
    data_t data;
    logic  err;
    logic  exokay;
  } rsp_entry_t;

endpackage

//--- common/amo_if.sv
// Captured atomic operation passed from the decoder to the sequencer

interface amo_if;
  import atop_pkg::*;

  // Strobe for one cycle on the grant of an AMO
  logic  start;
  atop_e op;
  addr_t addr;
  id_t   id;
  // Write data of the request, the second ALU operand
  data_t operand;

  modport decoder (
    output start, op, addr, id, operand
  );

  modport sequencer (
    input start, op, addr, id, operand
  );

endinterface

//--- rtl/amo/amo_alu.sv
// Atomic ALU for the nine RISC-V AMO operations
// A single adder with carry-in serves add and all four compares

`include "atop_settings.svh"

module amo_alu (
  input  atop_pkg::atop_e op_i,
  input  atop_pkg::data_t mem_data_i,
  input  atop_pkg::data_t operand_i,
  output atop_pkg::data_t result_o
);
  import atop_pkg::*;

  localparam int DW = `ATOP_DATA_WIDTH;

  logic          sgn;
  logic          sub;
  logic [DW:0]   ext_a, ext_b, sum;
  logic          a_lt_b;

  // Sign extension for the signed compares, zero extension otherwise
  assign sgn   = (op_i == AMO_MIN) || (op_i == AMO_MAX);
  assign sub   = (op_i == AMO_MIN) || (op_i == AMO_MAX) ||
                 (op_i == AMO_MINU) || (op_i == AMO_MAXU);
  assign ext_a = {sgn & mem_data_i[DW-1], mem_data_i};
  assign ext_b = {sgn & operand_i[DW-1], operand_i};

  // Subtraction is the inverted operand plus a carry-in
  assign sum    = ext_a + (ext_b ^ {(DW + 1){sub}}) + {{DW{1'b0}}, sub};
  assign a_lt_b = sum[DW];

  always_comb begin
    case (op_i)
      AMO_SWAP:           result_o = operand_i;
      AMO_ADD:            result_o = sum[DW-1:0];
      AMO_AND:            result_o = mem_data_i & operand_i;
      AMO_OR:             result_o = mem_data_i | operand_i;
      AMO_XOR:            result_o = mem_data_i ^ operand_i;
      AMO_MIN, AMO_MINU:  result_o = a_lt_b ? mem_data_i : operand_i;
      AMO_MAX, AMO_MAXU:  result_o = a_lt_b ? operand_i : mem_data_i;
      default:            result_o = operand_i;
    endcase
  end

endmodule

//--- rtl/amo/amo_sequencer.sv
// AMO sequencer
// Forwards plain requests and owns the memory port for the AMO write-back

`include "atop_settings.svh"

module amo_sequencer (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  amo_if.sequencer                      amo,
  input  logic                          req_i,
  input  atop_pkg::addr_t               addr_i,
  input  logic                          we_i,
  input  logic [`ATOP_DATA_WIDTH/8-1:0] be_i,
  input  atop_pkg::data_t               wdata_i,
  input  atop_pkg::id_t                 aid_i,
  input  logic                          sc_we_i,
  input  logic                          room_i,
  input  logic                          mem_gnt_i,
  input  logic                          mem_rvalid_i,
  input  atop_pkg::data_t               mem_rdata_i,
  output logic                          gnt_o,
  output logic                          idle_o,
  output logic                          writeback_o,
  output logic                          mem_req_o,
  output atop_pkg::addr_t               mem_addr_o,
  output logic                          mem_we_o,
  output logic [`ATOP_DATA_WIDTH/8-1:0] mem_be_o,
  output atop_pkg::data_t               mem_wdata_o,
  output atop_pkg::id_t                 mem_aid_o
);
  import atop_pkg::*;

  amo_state_e state_q, state_d;
  atop_e op_q;
  addr_t addr_q;
  id_t   id_q;
  data_t operand_q;
  data_t rdata_q;
  data_t old_value;
  data_t result;
  logic  wb_pending_q;
  logic  is_amo;

  // Opcode of the request currently presented
  assign is_amo = amo.op[5] & (amo.op != ATOP_LR) & (amo.op != ATOP_SC);

  // The old value is live on the read response and held afterwards
  assign old_value = mem_rvalid_i ? mem_rdata_i : rdata_q;

  amo_alu i_amo_alu (
    .op_i      (op_q),
    .mem_data_i(old_value),
    .operand_i (operand_q),
    .result_o  (result)
  );

  assign idle_o      = (state_q == IDLE);
  assign writeback_o = wb_pending_q;

  always_comb begin
    state_d     = state_q;
    gnt_o       = req_i & mem_gnt_i & room_i;
    mem_req_o   = req_i & room_i;
    mem_addr_o  = addr_i;
    // The AMO itself goes out as a read
    mem_we_o    = we_i & sc_we_i & ~is_amo;
    mem_be_o    = be_i;
    mem_wdata_o = wdata_i;
    mem_aid_o   = aid_i;
    case (state_q)
      IDLE: begin
        if (amo.start) begin
          state_d = WRITE_BACK;
        end
      end
      WRITE_BACK: begin
        gnt_o       = 1'b0;
        mem_req_o   = 1'b1;
        mem_addr_o  = addr_q;
        mem_we_o    = 1'b1;
        mem_be_o    = '1;
        mem_wdata_o = result;
        mem_aid_o   = id_q;
        if (mem_gnt_i) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  // --------------------
  // Registers

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= IDLE;
      wb_pending_q <= 1'b0;
    end else begin
      state_q <= state_d;
      // The next memory response after the write-back grant belongs to it
      if ((state_q == WRITE_BACK) && mem_gnt_i) begin
        wb_pending_q <= 1'b1;
      end else if (mem_rvalid_i) begin
        wb_pending_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (amo.start) begin
      op_q      <= amo.op;
      addr_q    <= amo.addr;
      id_q      <= amo.id;
      operand_q <= amo.operand;
    end
    if (mem_rvalid_i) begin
      rdata_q <= mem_rdata_i;
    end
  end

endmodule

//--- rtl/lrsc_monitor.sv
// Request classifier and LR/SC reservation tracker
// Starts AMOs on the sequencer interface and reports SC outcomes

module lrsc_monitor (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            grant_i,
  input  atop_pkg::addr_t addr_i,
  input  logic            we_i,
  input  atop_pkg::id_t   aid_i,
  input  atop_pkg::atop_e atop_i,
  input  atop_pkg::data_t wdata_i,
  amo_if.decoder          amo,
  output logic            sc_we_o,
  output logic            sc_result_o,
  output logic            sc_done_o
);
  import atop_pkg::*;

  typedef struct packed {
    logic  valid;
    addr_t addr;
    id_t   id;
  } reservation_t;

  reservation_t res_q, res_d;
  logic is_lr, is_sc, is_amo;
  logic sc_ok;
  logic result_d;

  assign is_lr  = (atop_i == ATOP_LR);
  assign is_sc  = (atop_i == ATOP_SC);
  assign is_amo = atop_i[5] & ~is_lr & ~is_sc;

  // The SC succeeds when its requester holds the reservation on this address
  assign sc_ok = is_sc & res_q.valid & (res_q.id == aid_i) & (res_q.addr == addr_i);

  // An SC arrives as a store and only keeps its write enable when it succeeds
  assign sc_we_o = ~is_sc | sc_ok;

  assign amo.start   = grant_i & is_amo;
  assign amo.op      = atop_i;
  assign amo.addr    = addr_i;
  assign amo.id      = aid_i;
  assign amo.operand = wdata_i;

  always_comb begin
    res_d    = res_q;
    result_d = 1'b0;
    if (grant_i) begin
      if (is_lr && (!res_q.valid || res_q.id == aid_i)) begin
        res_d    = '{valid: 1'b1, addr: addr_i, id: aid_i};
        result_d = 1'b1;
      end
      // A foreign store or AMO to the reserved word breaks the reservation
      if ((aid_i != res_q.id) && (addr_i == res_q.addr) && (is_amo || we_i)) begin
        res_d.valid = 1'b0;
      end
      if (is_sc && res_q.valid && (res_q.id == aid_i)) begin
        res_d.valid = 1'b0;
        result_d    = sc_ok;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      res_q       <= '0;
      sc_result_o <= 1'b0;
      sc_done_o   <= 1'b0;
    end else begin
      res_q       <= res_d;
      sc_result_o <= result_d;
      sc_done_o   <= grant_i & is_sc;
    end
  end

endmodule

//--- rtl/response_queue.sv
// Response queue for the requester port
// Ids are written on grant and data on the memory response, both in order

`include "atop_settings.svh"

module response_queue (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            grant_i,
  input  atop_pkg::id_t   aid_i,
  input  logic            writeback_i,
  input  logic            sc_done_i,
  input  logic            sc_result_i,
  input  logic            mem_rvalid_i,
  input  atop_pkg::data_t mem_rdata_i,
  input  logic            mem_err_i,
  output logic            room_o,
  output logic            rvalid_o,
  output atop_pkg::data_t rdata_o,
  output atop_pkg::id_t   rid_o,
  output logic            err_o,
  output logic            exokay_o
);
  import atop_pkg::*;

  localparam int DEPTH = `ATOP_RSP_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);

  // Slot k holds the id of grant k and later the data of response k
  rsp_entry_t entries_q [DEPTH];
  rsp_entry_t incoming, head;
  logic [PTR_W-1:0] id_wptr_q, data_wptr_q, rptr_q;
  logic [PTR_W:0]   id_cnt_q, data_cnt_q;
  logic push_data;
  logic pop;

  assign push_data = mem_rvalid_i & ~writeback_i;

  // An SC reports 0 on success and 1 on failure
  always_comb begin
    incoming.id     = entries_q[rptr_q].id;
    incoming.data   = sc_done_i ? {{(`ATOP_DATA_WIDTH - 1){1'b0}}, ~sc_result_i} : mem_rdata_i;
    incoming.err    = mem_err_i;
    incoming.exokay = sc_result_i;
    head = (data_cnt_q == '0) ? incoming : entries_q[rptr_q];
  end

  assign rvalid_o = (id_cnt_q != '0) & ((data_cnt_q != '0) | push_data);
  assign pop      = rvalid_o;
  assign room_o   = (id_cnt_q < DEPTH);
  assign rdata_o  = head.data;
  assign rid_o    = head.id;
  assign err_o    = head.err;
  assign exokay_o = head.exokay;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      id_wptr_q   <= '0;
      data_wptr_q <= '0;
      rptr_q      <= '0;
      id_cnt_q    <= '0;
      data_cnt_q  <= '0;
    end else begin
      id_wptr_q   <= id_wptr_q + PTR_W'(grant_i);
      data_wptr_q <= data_wptr_q + PTR_W'(push_data);
      rptr_q      <= rptr_q + PTR_W'(pop);
      id_cnt_q    <= id_cnt_q + (PTR_W + 1)'(grant_i) - (PTR_W + 1)'(pop);
      data_cnt_q  <= data_cnt_q + (PTR_W + 1)'(push_data) - (PTR_W + 1)'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (grant_i) begin
      entries_q[id_wptr_q].id <= aid_i;
    end
    if (push_data) begin
      entries_q[data_wptr_q].data   <= incoming.data;
      entries_q[data_wptr_q].err    <= incoming.err;
      entries_q[data_wptr_q].exokay <= incoming.exokay;
    end
  end

endmodule

//--- rtl/atop_resolver.sv
// Atomic-operation resolver top level
// Connects the LR/SC monitor, the AMO sequencer and the response queue

`include "atop_settings.svh"

module atop_resolver (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  // Requester port
  input  logic                             req_i,
  input  atop_pkg::addr_t                  addr_i,
  input  logic                             we_i,
  input  logic [`ATOP_DATA_WIDTH/8-1:0]    be_i,
  input  atop_pkg::data_t                  wdata_i,
  input  atop_pkg::id_t                    aid_i,
  input  atop_pkg::atop_e                  atop_i,
  output logic                             gnt_o,
  output logic                             rvalid_o,
  output atop_pkg::data_t                  rdata_o,
  output atop_pkg::id_t                    rid_o,
  output logic                             err_o,
  output logic                             exokay_o,
  // Memory port
  output logic                             mem_req_o,
  output atop_pkg::addr_t                  mem_addr_o,
  output logic                             mem_we_o,
  output logic [`ATOP_DATA_WIDTH/8-1:0]    mem_be_o,
  output atop_pkg::data_t                  mem_wdata_o,
  output atop_pkg::id_t                    mem_aid_o,
  input  logic                             mem_gnt_i,
  input  logic                             mem_rvalid_i,
  input  atop_pkg::data_t                  mem_rdata_i,
  input  logic                             mem_err_i
);

  amo_if amo ();

  logic sc_we;
  logic sc_result;
  logic sc_done;
  logic room;
  // Sequencer is not busy with a write-back
  logic seq_idle;
  logic writeback;

  // gnt_o is only raised together with req_i, so it marks the transfer cycle
  lrsc_monitor i_lrsc_monitor (
    .clk_i,
    .rst_ni,
    .grant_i    (gnt_o),
    .addr_i,
    .we_i,
    .aid_i,
    .atop_i,
    .wdata_i,
    .amo        (amo.decoder),
    .sc_we_o    (sc_we),
    .sc_result_o(sc_result),
    .sc_done_o  (sc_done)
  );

  amo_sequencer i_amo_sequencer (
    .clk_i,
    .rst_ni,
    .amo         (amo.sequencer),
    .req_i,
    .addr_i,
    .we_i,
    .be_i,
    .wdata_i,
    .aid_i,
    .sc_we_i     (sc_we),
    .room_i      (room),
    .mem_gnt_i,
    .mem_rvalid_i,
    .mem_rdata_i,
    .gnt_o,
    .idle_o      (seq_idle),
    .writeback_o (writeback),
    .mem_req_o,
    .mem_addr_o,
    .mem_we_o,
    .mem_be_o,
    .mem_wdata_o,
    .mem_aid_o
  );

  response_queue i_response_queue (
    .clk_i,
    .rst_ni,
    .grant_i     (gnt_o),
    .aid_i,
    .writeback_i (writeback),
    .sc_done_i   (sc_done),
    .sc_result_i (sc_result),
    .mem_rvalid_i,
    .mem_rdata_i,
    .mem_err_i,
    .room_o      (room),
    .rvalid_o,
    .rdata_o,
    .rid_o,
    .err_o,
    .exokay_o
  );

endmodule

//--- test/tb_clock.sv
// Clock and reset generator for the resolver testbench
// 100 ns clock period, reset held low for 16 cycles

module tb_clock (
  output logic clk_o,
  output logic rst_no
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_o = 1'b0;
    forever #50 clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (16) @(posedge clk_o);
    #1;
    rst_no = 1'b1;
  end

endmodule

//--- test/atop_resolver_props.sv
// Concurrent assertions on the resolver top level
// Reset state, pass-through, AMO write-back and grant blocking

module atop_resolver_props (
  input logic                  clk_i,
  input logic                  rst_ni,
  input logic                  req_i,
  input atop_pkg::addr_t       addr_i,
  input logic                  we_i,
  input logic [3:0]            be_i,
  input atop_pkg::data_t       wdata_i,
  input atop_pkg::id_t         aid_i,
  input atop_pkg::atop_e       atop_i,
  input logic                  gnt_o,
  input logic                  rvalid_o,
  input logic                  mem_req_o,
  input atop_pkg::addr_t       mem_addr_o,
  input logic                  mem_we_o,
  input logic [3:0]            mem_be_o,
  input atop_pkg::data_t       mem_wdata_o,
  input atop_pkg::id_t         mem_aid_o,
  input logic                  mem_gnt_i,
  input atop_pkg::data_t       mem_rdata_i,
  input logic                  seq_idle
);
  timeunit 1ns;
  timeprecision 100ps;
  import atop_pkg::*;

  int unsigned fail_count = 0;
  atop_e op_q;
  data_t opd_q;
  data_t old_q;
  logic  first_wb_q;
  logic  amo_grant;
  data_t old_value;

  assign amo_grant = gnt_o && atop_i[5] && (atop_i != ATOP_LR) && (atop_i != ATOP_SC);
  // The read data arrives in the first write-back cycle and is held afterwards
  assign old_value = first_wb_q ? mem_rdata_i : old_q;

  function automatic data_t amo_calc(atop_e op, data_t a, data_t b);
    case (op)
      AMO_SWAP: return b;
      AMO_ADD:  return a + b;
      AMO_AND:  return a & b;
      AMO_OR:   return a | b;
      AMO_XOR:  return a ^ b;
      AMO_MIN:  return ($signed(a) < $signed(b)) ? a : b;
      AMO_MAX:  return ($signed(a) > $signed(b)) ? a : b;
      AMO_MINU: return (a < b) ? a : b;
      AMO_MAXU: return (a > b) ? a : b;
      default:  return b;
    endcase
  endfunction

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      op_q       <= ATOP_NONE;
      opd_q      <= '0;
      old_q      <= '0;
      first_wb_q <= 1'b0;
    end else begin
      first_wb_q <= amo_grant;
      if (amo_grant) begin
        op_q  <= atop_i;
        opd_q <= wdata_i;
      end
      if (first_wb_q) begin
        old_q <= mem_rdata_i;
      end
    end
  end

  // --------------------
  // Properties

  reset_quiet: assert property (@(posedge clk_i)
    !rst_ni |-> !gnt_o && !mem_req_o && !rvalid_o)
    else begin $error("Outputs active during reset"); fail_count++; end

  idle_quiet: assert property (@(posedge clk_i) disable iff (!rst_ni)
    seq_idle && !req_i |-> !gnt_o && !mem_req_o)
    else begin $error("Grant or memory request without a request"); fail_count++; end

  passthrough: assert property (@(posedge clk_i) disable iff (!rst_ni)
    gnt_o && (atop_i == ATOP_NONE) |-> mem_req_o && (mem_addr_o == addr_i) &&
      (mem_we_o == we_i) && (mem_be_o == be_i) && (mem_wdata_o == wdata_i) &&
      (mem_aid_o == aid_i))
    else begin $error("Plain access not forwarded unchanged"); fail_count++; end

  amo_write: assert property (@(posedge clk_i) disable iff (!rst_ni)
    amo_grant |=> mem_req_o && mem_we_o && (mem_be_o == 4'hf) &&
      (mem_addr_o == $past(addr_i)))
    else begin $error("AMO write-back request malformed"); fail_count++; end

  amo_data: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !seq_idle && mem_gnt_i |-> mem_wdata_o == amo_calc(op_q, old_value, opd_q))
    else begin $error("AMO write-back data wrong"); fail_count++; end

  busy_no_grant: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !seq_idle |-> !gnt_o)
    else begin $error("Grant while the sequencer owns the memory port"); fail_count++; end

endmodule

bind atop_resolver atop_resolver_props props (.*);

//--- test/atop_resolver_tb.sv
// Testbench top for the atomic-operation resolver
// Memory model, directed and random stimulus, reference memory and report

module atop_resolver_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import atop_pkg::*;

  localparam int TIMEOUT = 1000;

  typedef struct {
    string name;
    id_t   id;
    data_t data;
    logic  exokay;
  } expect_t;

  logic       clk_i;
  logic       rst_ni;
  logic       req_i;
  addr_t      addr_i;
  logic       we_i;
  logic [3:0] be_i;
  data_t      wdata_i;
  id_t        aid_i;
  atop_e      atop_i;
  logic       gnt_o;
  logic       rvalid_o;
  data_t      rdata_o;
  id_t        rid_o;
  logic       err_o;
  logic       exokay_o;
  logic       mem_req_o;
  addr_t      mem_addr_o;
  logic       mem_we_o;
  logic [3:0] mem_be_o;
  data_t      mem_wdata_o;
  id_t        mem_aid_o;
  logic       mem_gnt_i;
  logic       mem_rvalid_i;
  data_t      mem_rdata_i;
  logic       mem_err_i;

  data_t       mem [16];
  data_t       ref_mem [16];
  logic        mem_hit;
  data_t       mem_old;
  logic [31:0] gnt_seed;
  logic [31:0] mix_seed;
  expect_t     exp_q [$];
  logic        res_v;
  addr_t       res_a;
  id_t         res_id;
  string       test_name;
  int          rsp_errors;
  int          mem_errors;
  logic        timed_out;
  atop_e       amo_ops [9] = '{AMO_SWAP, AMO_ADD, AMO_AND, AMO_OR, AMO_XOR,
                               AMO_MIN, AMO_MAX, AMO_MINU, AMO_MAXU};

  tb_clock i_clock (.clk_o(clk_i), .rst_no(rst_ni));

  atop_resolver uut (.*);

  function automatic logic [31:0] lcg_next(logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic data_t amo_reference(atop_e op, data_t a, data_t b);
    case (op)
      AMO_SWAP: return b;
      AMO_ADD:  return a + b;
      AMO_AND:  return a & b;
      AMO_OR:   return a | b;
      AMO_XOR:  return a ^ b;
      AMO_MIN:  return ($signed(a) < $signed(b)) ? a : b;
      AMO_MAX:  return ($signed(a) > $signed(b)) ? a : b;
      AMO_MINU: return (a < b) ? a : b;
      AMO_MAXU: return (a > b) ? a : b;
      default:  return b;
    endcase
  endfunction

  // Applies one granted request to the reference memory and reservation
  function automatic expect_t apply_reference(atop_e op, addr_t a, logic we,
                                              logic [3:0] be, data_t wd, id_t id);
    expect_t e;
    data_t   old;
    logic    is_amo;
    logic    ok;
    old    = ref_mem[a[5:2]];
    is_amo = op[5] && (op != ATOP_LR) && (op != ATOP_SC);
    e.name   = test_name;
    e.id     = id;
    e.data   = old;
    e.exokay = 1'b0;
    if (res_v && (id != res_id) && (a == res_a) && (we || is_amo)) begin
      res_v = 1'b0;
    end
    if (op == ATOP_LR) begin
      if (!res_v || (res_id == id)) begin
        res_v    = 1'b1;
        res_a    = a;
        res_id   = id;
        e.exokay = 1'b1;
      end
    end else if (op == ATOP_SC) begin
      ok = res_v && (res_id == id) && (res_a == a);
      if (res_v && (res_id == id)) begin
        res_v = 1'b0;
      end
      e.data   = ok ? 32'd0 : 32'd1;
      e.exokay = ok;
      if (ok) begin
        ref_mem[a[5:2]] = wd;
      end
    end else if (is_amo) begin
      ref_mem[a[5:2]] = amo_reference(op, old, wd);
    end else if (we) begin
      for (int b = 0; b < 4; b++) begin
        if (be[b]) ref_mem[a[5:2]][8*b +: 8] = wd[8*b +: 8];
      end
    end
    return e;
  endfunction

  // Memory model with pseudo-random grants and a one-cycle response
  always @(posedge clk_i) begin
    mem_hit = mem_req_o && mem_gnt_i;
    mem_old = mem[mem_addr_o[5:2]];
    if (mem_hit && mem_we_o) begin
      for (int b = 0; b < 4; b++) begin
        if (mem_be_o[b]) mem[mem_addr_o[5:2]][8*b +: 8] = mem_wdata_o[8*b +: 8];
      end
    end
    #1;
    mem_rvalid_i = mem_hit;
    mem_rdata_i  = mem_hit ? mem_old : '0;
    gnt_seed     = lcg_next(gnt_seed);
    mem_gnt_i    = (gnt_seed[17:16] != 2'b00);
  end

  task automatic check_value(string name, string field, data_t exp, data_t act);
    if (exp !== act) begin
      $display("Fail %s %s: expected %h, actual %h", name, field, exp, act);
      rsp_errors++;
    end
  endtask

  always @(posedge clk_i) begin
    expect_t e;
    if (rst_ni && rvalid_o) begin
      if (exp_q.size() == 0) begin
        $display("Response arrived with no request outstanding");
        rsp_errors++;
      end else begin
        e = exp_q.pop_front();
        check_value(e.name, "rid", data_t'(e.id), data_t'(rid_o));
        check_value(e.name, "rdata", e.data, rdata_o);
        check_value(e.name, "exokay", data_t'(e.exokay), data_t'(exokay_o));
        check_value(e.name, "err", 32'd0, data_t'(err_o));
      end
    end
  end

  task automatic issue(atop_e op, addr_t a, logic we, logic [3:0] be, data_t wd, id_t id);
    int cycles;
    if (!timed_out) begin
      req_i   = 1'b1;
      atop_i  = op;
      addr_i  = a;
      we_i    = we;
      be_i    = be;
      wdata_i = wd;
      aid_i   = id;
      cycles  = 0;
      do begin
        @(posedge clk_i);
        cycles++;
      end while (!gnt_o && cycles < TIMEOUT);
      if (!gnt_o) begin
        $display("Timed out waiting for a grant in %s", test_name);
        timed_out = 1'b1;
      end else begin
        exp_q.push_back(apply_reference(op, a, we, be, wd, id));
      end
      #1;
      req_i  = 1'b0;
      we_i   = 1'b0;
      atop_i = ATOP_NONE;
    end
  endtask

  initial begin
    int cycles;
    int k;
    req_i = 1'b0;
    addr_i = '0;
    we_i = 1'b0;
    be_i = '0;
    wdata_i = '0;
    aid_i = '0;
    atop_i = ATOP_NONE;
    mem_gnt_i = 1'b0;
    mem_rvalid_i = 1'b0;
    mem_rdata_i = '0;
    mem_err_i = 1'b0;
    gnt_seed = 32'hf79f4761;
    mix_seed = 32'hf79f4761;
    res_v = 1'b0;
    res_a = '0;
    res_id = '0;
    rsp_errors = 0;
    mem_errors = 0;
    timed_out = 1'b0;
    for (int i = 0; i < 16; i++) begin
      mem[i]     = 32'h9e3779b9 * (i + 1);
      ref_mem[i] = mem[i];
    end
    cycles = 0;
    while (!rst_ni && cycles < 100) begin
      @(posedge clk_i);
      cycles++;
    end
    if (!rst_ni) begin
      $display("Reset was not released");
      timed_out = 1'b1;
    end
    @(posedge clk_i);
    #1;

    test_name = "plain";
    issue(ATOP_NONE, 32'h4, 1'b1, 4'b0101, 32'hcafe_f00d, 4'd1);
    issue(ATOP_NONE, 32'h4, 1'b0, 4'hf, 32'h0, 4'd2);
    test_name = "amo";
    for (int i = 0; i < 9; i++) begin
      issue(amo_ops[i], addr_t'(i * 4), 1'b1, 4'hf,
            (i % 2) ? 32'hffff_fff0 + i : 32'h1234 * (i + 1), id_t'(i));
      issue(ATOP_NONE, addr_t'(i * 4), 1'b0, 4'hf, 32'h0, id_t'(i));
    end
    test_name = "lrsc_ok";
    issue(ATOP_LR, 32'h20, 1'b0, 4'hf, 32'h0, 4'd2);
    issue(ATOP_SC, 32'h20, 1'b1, 4'hf, 32'h5a5a_0001, 4'd2);
    test_name = "lrsc_fail";
    issue(ATOP_LR, 32'h24, 1'b0, 4'hf, 32'h0, 4'd3);
    issue(ATOP_NONE, 32'h24, 1'b1, 4'hf, 32'h1111_2222, 4'd5);
    issue(ATOP_SC, 32'h24, 1'b1, 4'hf, 32'h3333_4444, 4'd3);

    test_name = "random";
    for (int n = 0; n < 200; n++) begin
      mix_seed = lcg_next(mix_seed);
      k = int'(mix_seed[19:16]) % 11;
      mix_seed = lcg_next(mix_seed);
      if (k < 2) begin
        issue(ATOP_NONE, {26'd0, mix_seed[23:20], 2'b00}, k == 1, mix_seed[27:24],
              lcg_next(mix_seed), mix_seed[31:28]);
      end else begin
        issue(amo_ops[k - 2], {26'd0, mix_seed[23:20], 2'b00}, 1'b1, 4'hf,
              lcg_next(mix_seed), mix_seed[31:28]);
      end
    end

    // The last write-back may still be waiting for the memory
    cycles = 0;
    while ((exp_q.size() != 0 || mem_req_o) && cycles < TIMEOUT) begin
      @(posedge clk_i);
      #1;
      cycles++;
    end
    if (exp_q.size() != 0 || mem_req_o) begin
      $display("Timed out with %0d responses outstanding or a memory request pending",
               exp_q.size());
      timed_out = 1'b1;
    end
    for (int i = 0; i < 16; i++) begin
      if (mem[i] !== ref_mem[i]) begin
        $display("Fail memory word %0d: expected %h, actual %h", i, ref_mem[i], mem[i]);
        mem_errors++;
      end
    end
    $display("Errors: responses %0d, memory %0d, assertions %0d, timeout %0d",
             rsp_errors, mem_errors, uut.props.fail_count, timed_out);
    if (timed_out || rsp_errors != 0 || mem_errors != 0 || uut.props.fail_count != 0) begin
      $display("*** TEST FAILED ***");
    end else begin
      $display("*** TEST PASSED ***");
    end
    $finish;
  end

endmodule

//--- atop_resolver.f
+incdir+common
common/atop_pkg.sv
common/amo_if.sv
rtl/amo/amo_alu.sv
rtl/amo/amo_sequencer.sv
rtl/lrsc_monitor.sv
rtl/response_queue.sv
rtl/atop_resolver.sv
test/tb_clock.sv
test/atop_resolver_props.sv
test/atop_resolver_tb.sv

//--- Makefile
SIM      := verilator
TOP      := atop_resolver_tb
FILELIST := atop_resolver.f
FLAGS    := --binary --timing --assert --top-module $(TOP)
OBJ_DIR  := obj_dir
LOG      := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qF "*** TEST PASSED ***" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
